//--- sources.f
pq_types_pkg.sv
pq_ctrl_pkg.sv
pq_mem_if.sv
pq_bram.sv
pq_datapath.sv
pq_control_fsm.sv
pq_top.sv
pq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the priority queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --top-module pq_tb \
  -f sources.f -Mdir "$BUILD" -o pq_sim
if [ $? -ne 0 ]; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

"./$BUILD/pq_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "ERROR: simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "Test failures found" "$LOG"; then
  echo "RESULT: FAIL"
  exit 1
fi

echo "RESULT: PASS"
exit 0

//--- pq_tb.sv
module pq_tb
  import pq_types_pkg::*;
  import pq_ctrl_pkg::*;
;

  typedef enum logic [1:0] {
    op_enq,
    op_deq,
    op_enq_busy,
    op_mix
  } op_kind_t;

  typedef struct packed {
    op_kind_t   op;
    logic       use_rnd;
    key_t       key;
    logic [3:0] test_no;
  } entry_t;

  logic   clk;
  logic   rst;
  logic   enq;
  logic   deq;
  key_t   enq_data;
  key_t   deq_data;
  logic   busy;
  logic   done;
  logic   ok;
  logic   full;
  logic   empty;
  count_t count;

  entry_t      stim[$];
  key_t        model_q[$];
  logic [31:0] rng;
  key_t        last_deq;
  logic        have_last;
  logic        timed_out;
  logic [3:0]  cur_test;
  int          errors;
  int          test_errors;
  int          test_ops;
  int          tests_run;
  int          tests_failed;

  pq_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .enq      (enq),
    .deq      (deq),
    .enq_data (enq_data),
    .deq_data (deq_data),
    .busy     (busy),
    .done     (done),
    .ok       (ok),
    .full     (full),
    .empty    (empty),
    .count    (count)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_entry(input op_kind_t op, input logic use_rnd, input key_t key,
                           input logic [3:0] test_no);
    entry_t e;
    e.op      = op;
    e.use_rnd = use_rnd;
    e.key     = key;
    e.test_no = test_no;
    stim.push_back(e);
  endtask

  task automatic report_fail(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("Fail at %0t: test %0d, %s is %h, expected %h", $time, cur_test, what, got, exp);
    errors++;
    test_errors++;
  endtask

  task automatic report_test;
    tests_run++;
    if (test_errors == 0)
    begin
      $display("Test %0d passed, %0d operations", cur_test, test_ops);
    end
    else
    begin
      tests_failed++;
      $display("Test %0d failed, %0d errors", cur_test, test_errors);
    end
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic build_table;
    int i;
    add_entry(op_deq, 1'b0, '0, 4'd1);
    // Descending and mixed fixed keys
    add_entry(op_enq, 1'b0, 32'h0000_0900, 4'd2);
    add_entry(op_enq, 1'b0, 32'h0000_0800, 4'd2);
    add_entry(op_enq, 1'b0, 32'h0000_0700, 4'd2);
    add_entry(op_enq, 1'b0, 32'h0000_0050, 4'd2);
    add_entry(op_enq, 1'b0, 32'h0000_0a00, 4'd2);
    add_entry(op_enq, 1'b0, 32'h0000_0001, 4'd2);
    add_entry(op_enq, 1'b0, 32'h0000_0600, 4'd2);
    add_entry(op_enq, 1'b0, 32'h0000_0333, 4'd2);
    for (i = 0; i < 8; i++)
    begin
      add_entry(op_deq, 1'b0, '0, 4'd2);
    end
    // Duplicates and extremes
    add_entry(op_enq, 1'b0, 32'h0000_0005, 4'd3);
    add_entry(op_enq, 1'b0, 32'h0000_0005, 4'd3);
    add_entry(op_enq, 1'b0, 32'h0000_0000, 4'd3);
    add_entry(op_enq, 1'b0, 32'hffff_fffe, 4'd3);
    add_entry(op_enq, 1'b0, 32'h0000_0005, 4'd3);
    add_entry(op_enq, 1'b0, 32'h0000_0000, 4'd3);
    add_entry(op_enq, 1'b0, 32'h0000_0100, 4'd3);
    for (i = 0; i < 7; i++)
    begin
      add_entry(op_deq, 1'b0, '0, 4'd3);
    end
    // Fill to 16 plus one rejected enqueue
    for (i = 0; i < 17; i++)
    begin
      add_entry(op_enq, 1'b1, '0, 4'd4);
    end
    for (i = 0; i < 16; i++)
    begin
      add_entry(op_deq, 1'b0, '0, 4'd4);
    end
    // Dequeue strobes while busy
    add_entry(op_enq_busy, 1'b0, 32'h0000_0040, 4'd5);
    add_entry(op_enq_busy, 1'b0, 32'h0000_0010, 4'd5);
    add_entry(op_enq_busy, 1'b0, 32'h0000_0030, 4'd5);
    for (i = 0; i < 3; i++)
    begin
      add_entry(op_deq, 1'b0, '0, 4'd5);
    end
    for (i = 0; i < 60; i++)
    begin
      add_entry(op_mix, 1'b1, '0, 4'd6);
    end
  endtask

  ////////////////////
  // Operation
  ////////////////////

  task automatic wait_done;
    int          cycles;
    logic        got_done;
    ctrl_state_t st;
    cycles   = 0;
    got_done = 1'b0;
    while (!got_done && cycles < 200)
    begin
      @(negedge clk);
      cycles++;
      if (done)
      begin
        got_done = 1'b1;
      end
    end
    if (!got_done)
    begin
      st = dut_i.ctrl_i.state;
      $display("Timeout: no done within 200 cycles in test %0d, FSM state %s",
               cur_test, st.name());
      timed_out = 1'b1;
      errors++;
      test_errors++;
    end
  endtask

  task automatic apply_entry(input entry_t e);
    key_t key;
    logic is_enq;
    logic exp_ok;
    key_t exp_data;
    int   pos;
    key = e.key;
    if (e.use_rnd)
    begin
      rng = lcg_next(rng);
      key = rng;
    end
    is_enq = (e.op != op_deq);
    if (e.op == op_mix)
    begin
      rng    = lcg_next(rng);
      is_enq = rng[28];
    end

    @(posedge clk);
    enq      <= is_enq;
    deq      <= !is_enq;
    enq_data <= key;
    @(posedge clk);
    enq <= 1'b0;
    if (e.op == op_enq_busy)
    begin
      // FSM has left idle, this strobe must be dropped
      deq <= 1'b1;
      @(negedge clk);
      assert (busy == 1'b1)
      else report_fail("busy", 32'(busy), 32'd1);
      @(posedge clk);
      deq <= 1'b0;
    end
    else
    begin
      deq <= 1'b0;
    end
    wait_done();
    test_ops++;

    if (!timed_out)
    begin
      // Reference queue update
      exp_ok   = is_enq ? (model_q.size() < depth) : (model_q.size() != 0);
      exp_data = last_deq;
      if (exp_ok && is_enq)
      begin
        pos = 0;
        while (pos < model_q.size() && model_q[pos] <= key)
        begin
          pos++;
        end
        model_q.insert(pos, key);
      end
      else if (exp_ok)
      begin
        exp_data  = model_q.pop_front();
        last_deq  = exp_data;
        have_last = 1'b1;
      end

      assert (ok == exp_ok)
      else report_fail("ok", 32'(ok), 32'(exp_ok));
      assert (busy == 1'b0)
      else report_fail("busy at done", 32'(busy), 32'd0);
      assert (count == count_t'(model_q.size()))
      else report_fail("count", 32'(count), 32'(model_q.size()));
      assert (full == (model_q.size() == depth))
      else report_fail("full", 32'(full), 32'(model_q.size() == depth));
      assert (empty == (model_q.size() == 0))
      else report_fail("empty", 32'(empty), 32'(model_q.size() == 0));
      if (have_last)
      begin
        assert (deq_data == exp_data)
        else report_fail("deq_data", deq_data, exp_data);
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    rst      <= 1'b1;
    enq      <= 1'b0;
    deq      <= 1'b0;
    enq_data <= '0;
    rng          = 32'ha011_ccd1;
    have_last    = 1'b0;
    last_deq     = '0;
    timed_out    = 1'b0;
    errors       = 0;
    test_errors  = 0;
    test_ops     = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = 4'd1;
    build_table();

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (busy == 1'b0)
    else report_fail("busy after reset", 32'(busy), 32'd0);
    assert (done == 1'b0)
    else report_fail("done after reset", 32'(done), 32'd0);
    assert (empty == 1'b1)
    else report_fail("empty after reset", 32'(empty), 32'd1);
    assert (count == '0)
    else report_fail("count after reset", 32'(count), 32'd0);

    for (int i = 0; i < stim.size() && !timed_out; i++)
    begin
      if (stim[i].test_no != cur_test)
      begin
        report_test();
        cur_test    = stim[i].test_no;
        test_errors = 0;
        test_ops    = 0;
      end
      apply_entry(stim[i]);
    end
    report_test();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- pq_top.sv
module pq_top
  import pq_types_pkg::*;
  import pq_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   enq,
  input  logic   deq,
  input  key_t   enq_data,
  output key_t   deq_data,
  output logic   busy,
  output logic   done,
  output logic   ok,
  output logic   full,
  output logic   empty,
  output count_t count
);

  dp_op_t op;
  logic   less;

  ////////////////////
  // RAM port bundle
  ////////////////////

  pq_mem_if mem_if (
    .clk (clk)
  );

  ////////////////////
  // Blocks
  ////////////////////

  pq_control_fsm ctrl_i (
    .clk   (clk),
    .rst   (rst),
    .enq   (enq),
    .deq   (deq),
    .less  (less),
    .full  (full),
    .empty (empty),
    .count (count),
    .mem   (mem_if.ctrl),
    .op    (op),
    .busy  (busy),
    .done  (done),
    .ok    (ok)
  );

  pq_datapath dp_i (
    .clk    (clk),
    .rst    (rst),
    .mem    (mem_if.dp),
    .op     (op),
    .key_in (enq_data),
    .less   (less),
    .full   (full),
    .empty  (empty),
    .count  (count),
    .head   (deq_data)
  );

  pq_bram ram_i (
    .clk (clk),
    .mem (mem_if.mem)
  );

endmodule

//--- pq_control_fsm.sv
module pq_control_fsm
  import pq_types_pkg::*;
  import pq_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   enq,
  input  logic   deq,
  input  logic   less,
  input  logic   full,
  input  logic   empty,
  input  count_t count,
  pq_mem_if.ctrl mem,
  output dp_op_t op,
  output logic   busy,
  output logic   done,
  output logic   ok
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // Slot index for both passes
  addr_t idx;
  addr_t idx_nxt;
  addr_t idx_inc;
  addr_t idx_inc2;
  addr_t last_idx;
  addr_t tail_idx;

  logic ok_q;
  logic ok_nxt;

  assign idx_inc  = idx + addr_t'(1);
  assign idx_inc2 = idx + addr_t'(2);

  // Highest occupied slot, only meaningful when not empty
  assign last_idx = addr_t'(count - count_t'(1));

  // First free slot, the queue is not full when this is used
  assign tail_idx = addr_t'(count);

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idle;
      idx   <= '0;
      ok_q  <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      idx   <= idx_nxt;
      ok_q  <= ok_nxt;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb
  begin
    state_nxt   = state;
    idx_nxt     = idx;
    ok_nxt      = ok_q;
    op          = dp_hold;
    mem.rd_addr = idx;
    mem.wr_addr = idx;
    mem.we      = 1'b0;

    case (state)
      idle:
      begin
        // Slot 0 is read every idle cycle, ready for a dequeue
        mem.rd_addr = '0;
        idx_nxt     = '0;
        if (enq)
        begin
          op        = dp_load_key;
          state_nxt = enq_load;
        end
        else if (deq)
        begin
          // Carry holds the marker for a queue of one
          op        = dp_load_empty;
          state_nxt = deq_head;
        end
      end

      enq_load:
      begin
        if (full)
        begin
          ok_nxt    = 1'b0;
          state_nxt = finish;
        end
        else if (empty)
        begin
          state_nxt = enq_place;
        end
        else
        begin
          state_nxt = enq_read;
        end
      end

      enq_read:
      begin
        state_nxt = enq_compare;
      end

      enq_compare:
      begin
        if (less)
        begin
          state_nxt = enq_swap;
        end
        else if (idx == last_idx)
        begin
          state_nxt = enq_place;
        end
        else
        begin
          idx_nxt   = idx_inc;
          state_nxt = enq_read;
        end
      end

      enq_swap:
      begin
        // Carry goes into the slot, stored key goes into carry
        mem.we = 1'b1;
        op     = dp_swap;
        if (idx == last_idx)
        begin
          state_nxt = enq_place;
        end
        else
        begin
          idx_nxt   = idx_inc;
          state_nxt = enq_read;
        end
      end

      enq_place:
      begin
        mem.we      = 1'b1;
        mem.wr_addr = tail_idx;
        op          = dp_cnt_inc;
        ok_nxt      = 1'b1;
        state_nxt   = finish;
      end

      deq_head:
      begin
        if (empty)
        begin
          ok_nxt    = 1'b0;
          state_nxt = finish;
        end
        else
        begin
          op = dp_take_head;
          if (last_idx == '0)
          begin
            state_nxt = deq_clear;
          end
          else
          begin
            // Prefetch slot 1 for the first shift step
            mem.rd_addr = idx_inc;
            state_nxt   = deq_read;
          end
        end
      end

      deq_read:
      begin
        mem.rd_addr = idx_inc;
        op          = dp_load_mem;
        state_nxt   = deq_shift;
      end

      deq_shift:
      begin
        // Write slot i and fetch slot i+2 in the same cycle
        mem.we      = 1'b1;
        mem.rd_addr = idx_inc2;
        op          = dp_load_empty;
        if (idx_inc == last_idx)
        begin
          state_nxt = deq_clear;
        end
        else
        begin
          idx_nxt   = idx_inc;
          state_nxt = deq_read;
        end
      end

      deq_clear:
      begin
        mem.we      = 1'b1;
        mem.wr_addr = last_idx;
        op          = dp_cnt_dec;
        ok_nxt      = 1'b1;
        state_nxt   = finish;
      end

      finish:
      begin
        state_nxt = idle;
      end

      default:
      begin
        state_nxt = idle;
      end
    endcase
  end

  ////////////////////
  // Status
  ////////////////////

  assign busy = (state != idle) && (state != finish);
  assign done = (state == finish);
  assign ok   = done && ok_q;

endmodule

//--- pq_datapath.sv
module pq_datapath
  import pq_types_pkg::*;
  import pq_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  pq_mem_if.dp   mem,
  input  dp_op_t op,
  input  key_t   key_in,
  output logic   less,
  output logic   full,
  output logic   empty,
  output count_t count,
  output key_t   head
);

  key_t   carry;
  key_t   head_q;
  count_t cnt;

  ////////////////////
  // Carry register
  ////////////////////

  // Walks the slots during both passes
  always_ff @(posedge clk)
  begin
    case (op)
      dp_load_key:
      begin
        carry <= key_in;
      end
      dp_swap:
      begin
        // Stored key is larger, so it moves on
        carry <= mem.rd_data;
      end
      dp_load_mem:
      begin
        carry <= mem.rd_data;
      end
      dp_load_empty:
      begin
        carry <= empty_key;
      end
      default:
      begin
        carry <= carry;
      end
    endcase
  end

  // Carry is the only source of RAM write data
  assign mem.wr_data = carry;

  // Unsigned compare against the slot just read
  assign less = (carry < mem.rd_data);

  ////////////////////
  // Head register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (op == dp_take_head)
    begin
      head_q <= mem.rd_data;
    end
  end

  assign head = head_q;

  ////////////////////
  // Occupancy
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt <= '0;
    end
    else if (op == dp_cnt_inc)
    begin
      cnt <= cnt + count_t'(1);
    end
    else if (op == dp_cnt_dec)
    begin
      cnt <= cnt - count_t'(1);
    end
  end

  assign count = cnt;
  assign full  = (cnt == count_t'(depth));
  assign empty = (cnt == '0);

endmodule

//--- pq_bram.sv
module pq_bram
  import pq_types_pkg::*;
(
  input logic   clk,
  pq_mem_if.mem mem
);

  ////////////////////
  // Storage
  ////////////////////

  key_t ram [depth];

  // Synchronous write port
  always_ff @(posedge clk)
  begin
    if (mem.we)
    begin
      ram[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Registered read, old data on a same-address collision
  always_ff @(posedge clk)
  begin
    mem.rd_data <= ram[mem.rd_addr];
  end

endmodule

//--- pq_mem_if.sv
interface pq_mem_if
  import pq_types_pkg::*;
(
  input logic clk
);

  // Read port
  addr_t rd_addr;
  key_t  rd_data;

  // Write port, data always comes from the carry register
  addr_t wr_addr;
  logic  we;
  key_t  wr_data;

  modport ctrl (output rd_addr, output wr_addr, output we);

  modport dp (input rd_data, output wr_data);

  modport mem (
    input  clk,
    input  rd_addr,
    output rd_data,
    input  wr_addr,
    input  we,
    input  wr_data
  );

endinterface

//--- pq_ctrl_pkg.sv
package pq_ctrl_pkg;

  ////////////////////
  // FSM states
  ////////////////////

  typedef enum logic [3:0] {
    idle        = 4'd0,
    enq_load    = 4'd1,
    enq_read    = 4'd2,
    enq_compare = 4'd3,
    enq_swap    = 4'd4,
    enq_place   = 4'd5,
    deq_head    = 4'd6,
    deq_read    = 4'd7,
    deq_shift   = 4'd8,
    deq_clear   = 4'd9,
    finish      = 4'd10
  } ctrl_state_t;

  ////////////////////
  // Datapath opcodes
  ////////////////////

  typedef enum logic [2:0] {
    dp_hold       = 3'd0,
    dp_load_key   = 3'd1,
    dp_swap       = 3'd2,
    dp_load_mem   = 3'd3,
    dp_load_empty = 3'd4,
    dp_take_head  = 3'd5,
    dp_cnt_inc    = 3'd6,
    dp_cnt_dec    = 3'd7
  } dp_op_t;

endpackage

//--- pq_types_pkg.sv
package pq_types_pkg;

  ////////////////////
  // Data format
  ////////////////////

  localparam int key_width   = 32;
  localparam int depth       = 16;
  localparam int addr_width  = 4;
  // One extra bit so a full queue of 16 fits
  localparam int count_width = 5;

  typedef logic [key_width-1:0]   key_t;
  typedef logic [addr_width-1:0]  addr_t;
  typedef logic [count_width-1:0] count_t;

  // Written into slots that fall out of use
  localparam key_t empty_key = '1;

endpackage
